/* src/avl_bus_macros.svh */
`ifndef AVL_BUS_MACROS_SVH
`define AVL_BUS_MACROS_SVH

// Bus geometry
`define AVL_MASTER_NUM 4
`define AVL_ADDR_W     32
`define AVL_DATA_W     32
`define AVL_BURST_W    4

// Queue sizing, response FIFO may be 0, 2, 4, 8 or 16
`define AVL_SEL_FIFO_DEPTH  8
`define AVL_RESP_FIFO_DEPTH 4

`endif

/* src/avl_bus_pkg.sv */
`include "avl_bus_macros.svh"

package avl_bus_pkg;

  typedef logic [`AVL_ADDR_W-1:0]              avl_addr_t;
  typedef logic [`AVL_DATA_W-1:0]              avl_data_t;
  typedef logic [`AVL_DATA_W/8-1:0]            avl_be_t;    // One enable per data byte
  typedef logic [`AVL_BURST_W-1:0]             avl_burst_t;
  typedef logic [$clog2(`AVL_MASTER_NUM)-1:0]  avl_sel_t;   // Master index

  // Command channel, master to slave
  typedef struct packed {
    avl_addr_t  address;
    avl_be_t    byte_en;
    logic       read;
    logic       write;
    avl_data_t  write_data;
    logic       begin_burst_transfer;
    avl_burst_t burst_count;
  } avl_cmd_t;

  // Response channel, slave to master
  typedef struct packed {
    avl_data_t read_data;
    logic      read_data_valid;
  } avl_rsp_t;

  typedef enum logic {
    ARB_IDLE,
    ARB_HOLD
  } arb_state_t;

endpackage

/* src/avl_bus_arb.sv */
`timescale 1ns/1ns
`include "avl_bus_macros.svh"

module avl_bus_arb #(
  parameter int ARB_METHOD = 0  // 0 round-robin, 1 fixed priority
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [`AVL_MASTER_NUM-1:0] request,
  input  avl_bus_pkg::avl_cmd_t      granted_cmd,
  input  logic                       accept,
  output avl_bus_pkg::avl_sel_t      sel
);
  import avl_bus_pkg::*;

  arb_state_t state;
  avl_sel_t   next_sel;
  logic       gnt_req;

  assign gnt_req = granted_cmd.read | granted_cmd.write;  // Granted master is asking

  // --------------------------------------------------
  // Next grant candidate
  // --------------------------------------------------
  always_comb begin : next_grant
    int idx;
    next_sel = sel;  // Nobody requesting keeps the current grant
    if (ARB_METHOD == 0) begin
      // Walk downward so the nearest master after the current one wins
      for (int k = `AVL_MASTER_NUM; k >= 1; k--) begin
        idx = (int'(sel) + k) % `AVL_MASTER_NUM;
        if (request[idx]) begin
          next_sel = avl_sel_t'(idx);
        end
      end
    end else begin
      for (int k = `AVL_MASTER_NUM - 1; k >= 0; k--) begin
        if (request[k]) begin
          next_sel = avl_sel_t'(k);
        end
      end
    end
  end

  // --------------------------------------------------
  // Grant register and hold FSM
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ARB_IDLE;
      sel   <= '0;
    end else begin
      unique case (state)
        ARB_IDLE: begin
          if (gnt_req && !accept) begin
            state <= ARB_HOLD;  // Slave stalled, lock the grant
          end else begin
            sel <= next_sel;
          end
        end
        ARB_HOLD: begin
          // A held command, burst reads included, keeps the grant until it is taken
          if (accept || !gnt_req) begin
            state <= ARB_IDLE;
            sel   <= next_sel;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // An idle grant must move to a waiting master on the next cycle
  a_no_idle_grant: assert property (@(posedge clk) disable iff (!arst_n)
    (!request[sel] && |request) |=> (request[sel] || !(|request)))
    else $error("Grant stayed on an idle master while others were waiting");

endmodule

/* src/avl_sync_fifo.sv */
`timescale 1ns/1ns

module avl_sync_fifo #(
  parameter int DEPTH = 8,
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             write,
  input  logic             read,
  input  logic [WIDTH-1:0] write_data,
  output logic [WIDTH-1:0] read_data,
  output logic             full,
  output logic             empty
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign push      = write && !full;
  assign pop       = read && !empty;
  assign full      = (count == CNT_W'(DEPTH));
  assign empty     = (count == '0);
  assign read_data = mem[rd_ptr];  // Head is always on the output

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= write_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) !(write && full))
    else $error("Write into a full FIFO");
  a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) !(read && empty))
    else $error("Read from an empty FIFO");

endmodule

/* src/avl_resp_fifo.sv */
`timescale 1ns/1ns

module avl_resp_fifo #(
  parameter int DEPTH = 4  // 0 turns the FIFO into a plain bypass
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   write,
  input  logic                   read,
  input  avl_bus_pkg::avl_data_t write_data,
  output avl_bus_pkg::avl_data_t read_data,
  output logic                   full,
  output logic                   empty,
  output logic                   valid
);
  import avl_bus_pkg::*;

  if (DEPTH == 0) begin : g_bypass
    assign read_data = write_data;
    assign valid     = write;
    assign empty     = 1'b1;
    assign full      = write && !read;  // Beat not taken this cycle, slave must hold it
  end else begin : g_fifo
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    avl_data_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pass;
    logic             push;
    logic             pop;

    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign pass      = empty && write && read;   // Straight through, nothing stored
    assign push      = write && !full && !pass;
    assign pop       = read && !empty;
    assign valid     = !empty || write;
    assign read_data = empty ? write_data : mem[rd_ptr];

    always_ff @(posedge clk) begin
      if (push) begin
        mem[wr_ptr] <= write_data;
      end
    end

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (push) begin
          wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
          rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        count <= count + CNT_W'(push) - CNT_W'(pop);
      end
    end
  end

  // A beat refused while full has to be offered again unchanged
  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    (write && full) |=> (write && $stable(write_data)))
    else $error("Response beat dropped while the response FIFO was full");

endmodule

/* src/avl_bus_nm21.sv */
`timescale 1ns/1ns
`include "avl_bus_macros.svh"

module avl_bus_nm21 #(
  parameter int ARB_METHOD = 0  // 0 round-robin, 1 fixed priority
) (
  input  logic                       clk,
  input  logic                       arst_n,
  // Master side
  input  avl_bus_pkg::avl_cmd_t      m_cmd [`AVL_MASTER_NUM],
  output logic [`AVL_MASTER_NUM-1:0] m_request_ready,
  output avl_bus_pkg::avl_rsp_t      m_rsp [`AVL_MASTER_NUM],
  input  logic [`AVL_MASTER_NUM-1:0] m_resp_ready,
  // Slave side
  output avl_bus_pkg::avl_cmd_t      s_cmd,
  input  logic                       s_request_ready,
  input  avl_bus_pkg::avl_rsp_t      s_rsp,
  output logic                       s_resp_ready
);
  import avl_bus_pkg::*;

  // One entry per accepted read, owner and beat count
  typedef struct packed {
    avl_sel_t   sel;
    avl_burst_t len;
  } sel_entry_t;

  logic [`AVL_MASTER_NUM-1:0] request;
  avl_sel_t                   sel;
  avl_cmd_t                   granted_cmd;
  logic                       accept;

  sel_entry_t                 sel_wr;
  sel_entry_t                 sel_head;
  logic                       sel_push;
  logic                       sel_pop;
  logic                       sel_full;
  logic                       sel_empty;

  avl_data_t                  resp_data;
  logic                       resp_valid;
  logic                       resp_full;
  logic                       resp_empty;
  logic                       rsp_take;
  avl_burst_t                 beat_cnt;
  logic                       last_beat;

  // --------------------------------------------------
  // Command path
  // --------------------------------------------------
  assign granted_cmd = m_cmd[sel];

  always_comb begin
    s_cmd       = granted_cmd;
    s_cmd.read  = granted_cmd.read && !sel_full;   // No room to track another read
    s_cmd.write = granted_cmd.write && !sel_full;
  end

  assign accept   = (s_cmd.read || s_cmd.write) && s_request_ready;
  assign sel_push = s_cmd.read && s_request_ready;
  assign sel_wr   = '{sel: sel, len: granted_cmd.burst_count};

  // --------------------------------------------------
  // Per-master fan-out
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < `AVL_MASTER_NUM; i++) begin
      request[i]               = m_cmd[i].read || m_cmd[i].write;
      m_request_ready[i]       = (sel == avl_sel_t'(i)) && s_request_ready && !sel_full;
      m_rsp[i].read_data       = resp_data;
      m_rsp[i].read_data_valid = resp_valid && !sel_empty && (sel_head.sel == avl_sel_t'(i));
    end
  end

  // --------------------------------------------------
  // Response bookkeeping
  // --------------------------------------------------
  assign rsp_take     = resp_valid && !sel_empty && m_resp_ready[sel_head.sel];
  assign s_resp_ready = !resp_full;

  // A burst count of 0 is taken as a single beat
  assign last_beat = (sel_head.len <= avl_burst_t'(1)) ||
                     (beat_cnt == sel_head.len - avl_burst_t'(1));
  assign sel_pop   = rsp_take && last_beat;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      beat_cnt <= '0;
    end else if (rsp_take) begin
      beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
    end
  end

  avl_bus_arb #(
    .ARB_METHOD (ARB_METHOD)
  ) u_arb (
    .clk         (clk),
    .arst_n      (arst_n),
    .request     (request),
    .granted_cmd (granted_cmd),
    .accept      (accept),
    .sel         (sel)
  );

  avl_sync_fifo #(
    .DEPTH (`AVL_SEL_FIFO_DEPTH),
    .WIDTH ($bits(sel_entry_t))
  ) u_sel_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .write      (sel_push),
    .read       (sel_pop),
    .write_data (sel_wr),
    .read_data  (sel_head),
    .full       (sel_full),
    .empty      (sel_empty)
  );

  avl_resp_fifo #(
    .DEPTH (`AVL_RESP_FIFO_DEPTH)
  ) u_resp_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .write      (s_rsp.read_data_valid),
    .read       (rsp_take),
    .write_data (s_rsp.read_data),
    .read_data  (resp_data),
    .full       (resp_full),
    .empty      (resp_empty),
    .valid      (resp_valid)
  );

  // Every slave beat belongs to a read that is still tracked
  a_rsp_has_owner: assert property (@(posedge clk) disable iff (!arst_n)
    s_rsp.read_data_valid |-> !sel_empty)
    else $error("Slave response with no outstanding read");

  // Buffered beats always have an owner at the select FIFO head
  a_buffered_owner: assert property (@(posedge clk) disable iff (!arst_n)
    !resp_empty |-> !sel_empty)
    else $error("Response FIFO holds data with no outstanding read");

endmodule

/* dv/avl_bus_mem_model.sv */
`timescale 1ns/1ns

module avl_bus_mem_model #(
  parameter int STALL_PCT   = 30,  // Chance in percent of a cycle without request_ready
  parameter int MAX_LATENCY = 3    // Longest gap in cycles before a read beat
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  avl_bus_pkg::avl_cmd_t s_cmd,
  output logic                  s_request_ready,
  output avl_bus_pkg::avl_rsp_t s_rsp,
  input  logic                  s_resp_ready
);
  import avl_bus_pkg::*;

  avl_data_t mem     [256];  // Word store over address bits 9:2
  logic      written [256];
  avl_data_t beat_q  [$];    // Read beats not yet handed to the bus
  int        gap;

  always @(posedge clk or negedge arst_n) begin : slave
    int idx;
    int beats;
    if (!arst_n) begin
      s_request_ready <= 1'b0;
      s_rsp           <= '0;
      gap = 0;
      beat_q.delete();
      for (int i = 0; i < 256; i++) begin
        written[i] = 1'b0;
      end
    end else begin
      s_request_ready <= ($urandom % 100) >= STALL_PCT;
      idx = int'(s_cmd.address[9:2]);
      if (s_request_ready && s_cmd.write) begin
        for (int b = 0; b < 4; b++) begin
          if (s_cmd.byte_en[b]) begin
            mem[idx][8*b +: 8] = s_cmd.write_data[8*b +: 8];
          end
        end
        written[idx] = 1'b1;
      end
      if (s_request_ready && s_cmd.read) begin
        beats = (s_cmd.burst_count == '0) ? 1 : int'(s_cmd.burst_count);
        for (int b = 0; b < beats; b++) begin
          idx = (int'(s_cmd.address[9:2]) + b) % 256;  // Beats walk up word by word
          beat_q.push_back(written[idx] ? mem[idx] : (s_cmd.address ^ 32'hA5A5_0000) + b);
        end
      end

      // --------------------------------------------------
      // Response side, one beat at a time with a random gap
      // --------------------------------------------------
      if (s_rsp.read_data_valid && s_resp_ready) begin
        void'(beat_q.pop_front());
        s_rsp.read_data_valid <= 1'b0;
        gap = $urandom % (MAX_LATENCY + 1);
      end else if (!s_rsp.read_data_valid && beat_q.size() > 0) begin
        if (gap == 0) begin
          s_rsp.read_data       <= beat_q[0];
          s_rsp.read_data_valid <= 1'b1;
        end else begin
          gap--;
        end
      end
    end
  end

endmodule

/* dv/avl_bus_tb.sv */
`timescale 1ns/1ns
`include "avl_bus_macros.svh"

module avl_bus_tb;
  import avl_bus_pkg::*;

  localparam int NM           = `AVL_MASTER_NUM;
  localparam int NUM_LINES    = 24;
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;

  logic          clk = 1'b0;
  logic          arst_n;
  avl_cmd_t      m_cmd [NM];
  logic [NM-1:0] m_request_ready;
  avl_rsp_t      m_rsp [NM];
  logic [NM-1:0] m_resp_ready;
  avl_cmd_t      s_cmd;
  logic          s_request_ready;
  avl_rsp_t      s_rsp;
  logic          s_resp_ready;

  logic [31:0] pat [NUM_LINES*6];  // Six columns per pattern line
  logic        resp_rdy [NM];
  logic        rd_open [NM];                   // Master still expects read beats
  avl_cmd_t    issued [NM];                    // Command each master is offering
  int          skipped [NM] = '{default: 0};  // Accepts given to others while waiting
  int          slave_accepts = 0;
  int          done_cnt = 0;

  always #(CLK_PERIOD/2) clk = ~clk;

  avl_bus_nm21 #(.ARB_METHOD(0)) u_dut (
    .clk (clk), .arst_n (arst_n),
    .m_cmd (m_cmd), .m_request_ready (m_request_ready),
    .m_rsp (m_rsp), .m_resp_ready (m_resp_ready),
    .s_cmd (s_cmd), .s_request_ready (s_request_ready),
    .s_rsp (s_rsp), .s_resp_ready (s_resp_ready)
  );

  avl_bus_mem_model u_mem (
    .clk (clk), .arst_n (arst_n), .s_cmd (s_cmd), .s_request_ready (s_request_ready),
    .s_rsp (s_rsp), .s_resp_ready (s_resp_ready)
  );

  // --------------------------------------------------
  // Error reporting and bus helpers
  // --------------------------------------------------
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input avl_data_t got, input avl_data_t exp);
    stop_on_error($sformatf("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  function automatic avl_cmd_t build_command(input int ln);
    avl_cmd_t cmd;
    cmd                      = '0;
    cmd.address              = pat[ln*6+2];
    cmd.byte_en              = '1;
    cmd.write                = (pat[ln*6+1] == 32'd1);
    cmd.read                 = (pat[ln*6+1] == 32'd2);
    cmd.write_data           = cmd.write ? pat[ln*6+4] : '0;
    cmd.begin_burst_transfer = cmd.read;
    cmd.burst_count          = avl_burst_t'(pat[ln*6+3]);
    return cmd;
  endfunction

  // Ready does not depend on the command, so the falling edge shows the coming accept
  task automatic issue_command(input int m, input avl_cmd_t cmd);
    @(negedge clk);
    m_cmd[m] = cmd;
    while (!m_request_ready[m]) @(negedge clk);
    @(negedge clk);
    m_cmd[m] = '0;
  endtask

  task automatic collect_read(input int m, input int beats, input avl_data_t first,
                              input logic [7:0] stall);
    int k;
    for (int b = 0; b < beats; b++) begin
      k = 0;
      forever begin
        resp_rdy[m] = (k >= 8) || !stall[k];  // Stall bits cover the first offered cycles
        if (m_rsp[m].read_data_valid) begin
          assert (m_rsp[m].read_data == first + avl_data_t'(b))
            else report_mismatch($sformatf("m_rsp[%0d].read_data", m),
                                 m_rsp[m].read_data, first + avl_data_t'(b));
          if (resp_rdy[m]) break;
          k++;
        end
        @(negedge clk);
      end
      @(negedge clk);
    end
    resp_rdy[m] = 1'b0;
    rd_open[m]  = 1'b0;
  endtask

  // --------------------------------------------------
  // One driver per master
  // --------------------------------------------------
  for (genvar gm = 0; gm < NM; gm++) begin : g_master
    assign m_resp_ready[gm] = resp_rdy[gm];

    initial begin : drive
      avl_cmd_t cmd;
      m_cmd[gm]    = '0;
      issued[gm]   = '0;
      resp_rdy[gm] = 1'b0;
      rd_open[gm]  = 1'b0;
      wait (arst_n === 1'b1);
      for (int ln = 0; ln < NUM_LINES; ln++) begin
        if (pat[ln*6] == gm) begin
          cmd         = build_command(ln);
          rd_open[gm] = cmd.read;
          issued[gm]  = cmd;
          issue_command(gm, cmd);
          if (cmd.read) begin
            collect_read(gm, int'(cmd.burst_count), pat[ln*6+4], pat[ln*6+5][7:0]);
          end
        end
      end
      done_cnt += 1;
    end
  end

  // Read data must only reach a master that is waiting for it
  always @(negedge clk) begin
    for (int i = 0; i < NM; i++) begin
      assert (!arst_n || !m_rsp[i].read_data_valid || rd_open[i])
        else stop_on_error($sformatf("Master %0d got read data with no read outstanding", i));
    end
  end

  // Slave port values are settled at the rising edge
  always @(posedge clk) begin : fairness
    int served;
    if (arst_n && (s_cmd.read || s_cmd.write) && s_request_ready) begin
      slave_accepts++;
      served = int'(s_cmd.address[9:8]);  // Address region names the master
      assert (s_cmd == issued[served])
        else stop_on_error($sformatf("Mismatch at time %0t: s_cmd is %h, expected %h",
                                     $time, s_cmd, issued[served]));
      for (int i = 0; i < NM; i++) begin
        if (i == served) begin
          skipped[i] = 0;
        end else if (m_cmd[i].read || m_cmd[i].write) begin
          skipped[i]++;
        end
        assert (skipped[i] <= NM - 1)
          else stop_on_error($sformatf("Master %0d was passed over too often", i));
      end
    end
  end

  initial begin : watchdog
    #(CLK_PERIOD * (RESET_CYCLES + 200 * NUM_LINES));
    stop_on_error("Timeout, the masters did not finish their pattern lines in time");
  end

  initial begin : main
    int unsigned seed;
    seed = 32'h5a279ef6;
    void'($urandom(seed));
    $readmemh("dv/avl_bus_patterns.txt", pat);
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    wait (done_cnt == NM);
    repeat (2) @(negedge clk);
    assert (slave_accepts == NUM_LINES)
      else stop_on_error($sformatf("Slave accepted %0d commands, %0d were issued",
                                   slave_accepts, NUM_LINES));
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* list.f */
+incdir+src
src/avl_bus_pkg.sv
src/avl_bus_arb.sv
src/avl_sync_fifo.sv
src/avl_resp_fifo.sv
src/avl_bus_nm21.sv
dv/avl_bus_mem_model.sv
dv/avl_bus_tb.sv

/* Bender.yml */
package:
  name: avl_bus_nm21

sources:
  - include_dirs:
      - src
    files:
      - src/avl_bus_pkg.sv
      - src/avl_bus_arb.sv
      - src/avl_sync_fifo.sv
      - src/avl_resp_fifo.sv
      - src/avl_bus_nm21.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/avl_bus_mem_model.sv
      - dv/avl_bus_tb.sv

/* dv/avl_bus_patterns.txt */
// master  op (1 write, 2 read)  address  burst count  write word or first read word
// resp_ready stall mask, bit k holds resp_ready low on the k-th offered cycle of a beat
0 1 00000000 1 11110000 00
0 2 00000000 1 11110000 00
0 2 00000010 4 A5A50010 00
0 1 00000040 1 0BADF00D 00
0 2 00000040 1 0BADF00D 3C
0 2 00000080 2 A5A50080 A5
1 1 00000100 1 22221111 00
1 2 00000100 1 22221111 FF
1 2 00000120 8 A5A50120 00
1 2 00000104 1 A5A50104 0F
1 1 00000144 1 CAFE0144 00
1 2 00000144 1 CAFE0144 00
2 2 00000200 3 A5A50200 00
2 1 00000230 1 33332222 00
2 2 00000230 1 33332222 55
2 2 00000240 F A5A50240 00
2 1 00000280 1 DEADBEEF 00
2 2 00000280 1 DEADBEEF 81
3 2 00000300 1 A5A50300 00
3 2 00000304 1 A5A50304 00
3 1 00000308 1 44443333 00
3 2 00000308 1 44443333 F0
3 2 00000340 4 A5A50340 33
3 2 000003F0 2 A5A503F0 00
